/* compile.f */
+incdir+rtl
rtl/dispatch_pkg.sv
rtl/rob_pkg.sv
rtl/arch_reg_file.sv
rtl/reorder_buffer.sv
rtl/operand_select.sv
rtl/dispatch_stage.sv
verif/dispatch_stage_props.sv
verif/tb_dispatch_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dispatch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f compile.f --top-module tb_dispatch_stage -o sim_dispatch

out=$(./obj_dir/sim_dispatch 2>&1 || true)
echo "$out"

# Pass only if the testbench printed its pass line
grep -qx "Everything OK" <<< "$out"
echo "Simulation passed"

/* verif/tb_dispatch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module tb_dispatch_stage;

   import dispatch_pkg::*;
   import rob_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_CYCLES   = 2000;
   localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

   logic            clk;
   logic            rst_n_i;
   dispatch_req_t   req;
   cdb_result_t     cdb;
   logic            dispatch_ready;
   operand_bundle_t operands;
   commit_t         commit;

   // Stimulus for the next edge
   dispatch_req_t   next_req;
   cdb_result_t     next_cdb;
   logic [31:0]     rng_q;

   // ==========================================================
   // Reference model state, mirrors the DUT between edges
   // ==========================================================
   rob_entry_t            m_rob [`ROB_DEPTH];
   logic [`XLEN-1:0]      m_regs [`NUM_ARCH_REGS];
   logic [`ROB_IDX_W-1:0] m_head;
   logic [`ROB_IDX_W-1:0] m_tail;
   int                    m_count;
   operand_bundle_t       m_bundle;
   commit_t               m_commit;
   logic                  accepted;       // Request taken at the coming edge
   int                    alloc_total;    // Slots below this were allocated once
   int                    full_cycles;    // Refused requests seen
   int                    store_commits;
   int                    err_operands;
   int                    err_commit;
   int                    err_ready;
   int                    err_other;
   int                    total;

   dispatch_stage i_dut (
      .clk(clk), .rst_n_i(rst_n_i),
      .dispatch_req_i(req), .cdb_i(cdb),
      .dispatch_ready_o(dispatch_ready),
      .operands_o(operands), .commit_o(commit)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_q = xorshift32(rng_q);
      return rng_q;
   endfunction

   // Register source, or a ROB slot that has been allocated before
   function automatic logic [`PHYS_ADDR_W-1:0] pick_phys();
      logic [31:0] r;
      r = next_random();
      if (r[31] && alloc_total > 0) begin
         return {1'b1, (alloc_total >= `ROB_DEPTH) ? r[4:0] : 5'(r[15:0] % alloc_total)};
      end
      return {1'b0, r[4:0]};
   endfunction

   // Read rule, pre-edge state only
   function automatic operand_read_t model_read(input logic [`PHYS_ADDR_W-1:0] phys);
      operand_read_t r;
      if (phys[`PHYS_ADDR_W-1]) begin
         r.data  = m_rob[phys[4:0]].data;
         r.ready = (m_rob[phys[4:0]].state != ROB_BUSY);   // Free and done both usable
      end else begin
         r.data  = (phys[4:0] == '0) ? '0 : m_regs[phys[4:0]];   // x0 reads zero
         r.ready = 1'b1;
      end
      return r;
   endfunction

   task automatic model_reset();
      for (int i = 0; i < `ROB_DEPTH; i++) begin
         m_rob[i] = '{state: ROB_FREE, rd: '0, writes_rd: 1'b0, data: '0};
      end
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
         m_regs[i] = '0;
      end
      m_head      = '0;
      m_tail      = '0;
      m_count     = 0;
      m_bundle    = '0;
      m_commit    = '0;
      accepted    = 1'b0;
      alloc_total = 0;
   endtask

   // One clock edge of the model, using the inputs now applied
   task automatic model_step();
      operand_read_t ra;
      operand_read_t rb;
      logic          retire;
      logic          use_imm;
      ra       = model_read(req.rs1_phys);
      rb       = model_read(req.rs2_phys);
      accepted = req.valid && (m_count < `ROB_DEPTH);
      retire   = (m_rob[m_head].state == ROB_DONE);
      use_imm  = (req.opcode == OP_IMM) || (req.opcode == OP_STORE);
      if (req.valid && !accepted) full_cycles++;
      // Commit shown this cycle lands in the register file
      if (m_commit.valid && m_commit.we && m_commit.rd != '0) begin
         m_regs[m_commit.rd] = m_commit.data;
      end
      m_bundle.valid = accepted;
      if (accepted) begin
         m_bundle.opcode   = req.opcode;
         m_bundle.a_data   = ra.data;
         m_bundle.a_ready  = ra.ready;
         m_bundle.b_data   = use_imm ? req.imm : rb.data;
         m_bundle.b_ready  = use_imm || rb.ready;
         m_bundle.st_data  = rb.data;              // Store data from rs2 read
         m_bundle.st_ready = rb.ready;
         m_bundle.dest_idx = m_tail;
      end
      m_commit.valid = retire;
      if (retire) begin
         m_commit.we   = m_rob[m_head].writes_rd;
         m_commit.rd   = m_rob[m_head].rd;
         m_commit.data = m_rob[m_head].data;
         if (!m_rob[m_head].writes_rd) store_commits++;
      end
      if (cdb.valid) begin
         m_rob[cdb.idx].state = ROB_DONE;
         m_rob[cdb.idx].data  = cdb.data;
      end
      if (retire) begin
         m_rob[m_head].state = ROB_FREE;
         m_head = m_head + 5'd1;
      end
      if (accepted) begin
         m_rob[m_tail].state     = ROB_BUSY;
         m_rob[m_tail].rd        = req.rd;
         m_rob[m_tail].writes_rd = (req.opcode != OP_STORE);
         m_tail = m_tail + 5'd1;
         alloc_total++;
      end
      m_count = m_count + (accepted ? 1 : 0) - (retire ? 1 : 0);
   endtask

   task automatic pick_stimulus(input int cyc);
      logic [31:0] r;
      logic [2:0]  rate;
      int          busy_idx[$];
      r = next_random();
      if (req.valid && !accepted) begin
         next_req = req;                         // Refused, hold unchanged
      end else begin
         next_req.valid    = (r[1:0] != 2'b00);
         next_req.opcode   = opcode_e'(2'(r[7:2] % 3));
         next_req.rs1_phys = pick_phys();
         next_req.rs2_phys = pick_phys();
         next_req.imm      = next_random();
         next_req.rd       = r[12:8];
      end
      // Results starved early in each window so the ROB fills up
      rate = ((cyc % 400) < 150) ? 3'd1 : 3'd6;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
         if (m_rob[i].state == ROB_BUSY) busy_idx.push_back(i);
      end
      next_cdb = '0;
      if (busy_idx.size() > 0 && r[15:13] < rate) begin
         next_cdb.valid = 1'b1;
         next_cdb.idx   = 5'(busy_idx[r[31:16] % busy_idx.size()]);
         next_cdb.data  = next_random();
      end
   endtask

   // ==========================================================
   // Compare tasks
   // ==========================================================
   task automatic check_ready(input logic got, input logic exp);
      if (got !== exp) begin
         err_ready++;
         $display("MISMATCH at %0t: dispatch_ready_o %b, expected %b", $time, got, exp);
      end
   endtask

   task automatic check_operands(input operand_bundle_t got, input operand_bundle_t exp);
      logic bad;
      bad = (got.valid !== exp.valid);
      if (exp.valid) begin
         if (got.opcode !== exp.opcode || got.dest_idx !== exp.dest_idx) bad = 1'b1;
         if (got.a_ready !== exp.a_ready || got.b_ready !== exp.b_ready) bad = 1'b1;
         if (got.st_ready !== exp.st_ready) bad = 1'b1;
         if (exp.a_ready && got.a_data !== exp.a_data) bad = 1'b1;    // Busy data is stale
         if (exp.b_ready && got.b_data !== exp.b_data) bad = 1'b1;
         if (exp.st_ready && got.st_data !== exp.st_data) bad = 1'b1;
      end
      if (bad) begin
         err_operands++;
         $display("MISMATCH at %0t: operands %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic check_commit(input commit_t got, input commit_t exp);
      logic bad;
      bad = (got.valid !== exp.valid);
      if (exp.valid && (got.we !== exp.we || got.rd !== exp.rd || got.data !== exp.data)) begin
         bad = 1'b1;
      end
      if (bad) begin
         err_commit++;
         $display("MISMATCH at %0t: commit %h, expected %h", $time, got, exp);
      end
   endtask

   // ==========================================================
   // Main sequence
   // ==========================================================
   initial begin
      rng_q         = 32'h56c7fe4b;
      full_cycles   = 0;
      store_commits = 0;
      err_operands  = 0;
      err_commit    = 0;
      err_ready     = 0;
      err_other     = 0;
      rst_n_i <= 1'b0;
      req     <= '0;
      cdb     <= '0;
      model_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n_i <= 1'b1;
      for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
         @(negedge clk);                         // Outputs settled here
         check_ready(dispatch_ready, (m_count < `ROB_DEPTH));
         check_operands(operands, m_bundle);
         check_commit(commit, m_commit);
         model_step();
         pick_stimulus(cyc);
         @(posedge clk);
         req <= next_req;
         cdb <= next_cdb;
      end
      if (full_cycles == 0) begin
         $display("The reorder buffer never filled, back-pressure was not exercised");
         err_other++;
      end
      if (store_commits == 0) begin
         $display("No store reached commit during the run");
         err_other++;
      end
      err_other += i_dut.i_rob.i_props.fail_cnt;
      total = err_operands + err_commit + err_ready + err_other;
      $display("Errors: operands %0d, commit %0d, ready %0d, other %0d",
               err_operands, err_commit, err_ready, err_other);
      if (total == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Watchdog, full test length plus margin
   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired, the test did not finish in time");
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/dispatch_stage_props.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_stage_props (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    alloc_ready_i,
   input  logic [`ROB_IDX_W-1:0]   tail_i,          // Next slot to allocate
   input  logic                    retire_i,
   input  logic [`ROB_IDX_W:0]     count_i,
   input  logic                    cdb_valid_i,
   input  logic                    cdb_slot_free_i  // Target slot state is free
);

   int fail_cnt = 0;   // Failed assertions so far

   // ==========================================================
   // Occupancy and handshake
   // ==========================================================
   a_no_commit_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
      retire_i |-> (count_i != '0))
      else begin
         fail_cnt++;
         $error("Commit issued while the reorder buffer is empty");
      end

   a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n_i)
      !alloc_ready_i |=> $stable(tail_i))   // Full buffer keeps its tail
      else begin
         fail_cnt++;
         $error("Allocation while ready is low");
      end

   a_cdb_not_free: assert property (@(posedge clk) disable iff (!rst_n_i)
      cdb_valid_i |-> !cdb_slot_free_i)
      else begin
         fail_cnt++;
         $error("Result targets a free reorder buffer entry");
      end

endmodule

bind reorder_buffer dispatch_stage_props i_props (
   .clk(clk),
   .rst_n_i(rst_n_i),
   .alloc_ready_i(alloc_ready_o),
   .tail_i(tail_q),
   .retire_i(retire),
   .count_i(count_q),
   .cdb_valid_i(cdb_i.valid),
   .cdb_slot_free_i(entries_q[cdb_i.idx].state == rob_pkg::ROB_FREE)
);

`default_nettype wire

/* rtl/dispatch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_stage (
   input  logic                          clk,
   input  logic                          rst_n_i,
   input  dispatch_pkg::dispatch_req_t   dispatch_req_i,
   input  rob_pkg::cdb_result_t          cdb_i,
   output logic                          dispatch_ready_o,   // ROB has a free slot
   output dispatch_pkg::operand_bundle_t operands_o,
   output rob_pkg::commit_t              commit_o
);

   import dispatch_pkg::*;
   import rob_pkg::*;

   logic                      accept;
   dispatch_req_t             alloc_req;   // valid qualified by ready
   logic [`ROB_IDX_W-1:0]     alloc_idx;
   logic [`ARCH_ADDR_W-1:0]   rf_addr_a;
   logic [`ARCH_ADDR_W-1:0]   rf_addr_b;
   logic [`ROB_IDX_W-1:0]     rob_idx_a;
   logic [`ROB_IDX_W-1:0]     rob_idx_b;
   operand_read_t             rf_rd_a;
   operand_read_t             rf_rd_b;
   operand_read_t             rob_rd_a;
   operand_read_t             rob_rd_b;

   assign accept    = dispatch_req_i.valid && dispatch_ready_o;
   assign alloc_req = '{valid:    accept,
                        opcode:   dispatch_req_i.opcode,
                        rs1_phys: dispatch_req_i.rs1_phys,
                        rs2_phys: dispatch_req_i.rs2_phys,
                        imm:      dispatch_req_i.imm,
                        rd:       dispatch_req_i.rd};

   // ==========================================================
   // Register file and ROB, read side by side
   // ==========================================================
   arch_reg_file i_arf (
      .clk(clk), .rst_n_i(rst_n_i),
      .rd_addr_a_i(rf_addr_a), .rd_addr_b_i(rf_addr_b),
      .commit_i(commit_o),                            // Writes the retiring head
      .rd_a_o(rf_rd_a), .rd_b_o(rf_rd_b)
   );

   reorder_buffer i_rob (
      .clk(clk), .rst_n_i(rst_n_i),
      .alloc_i(alloc_req), .alloc_ready_o(dispatch_ready_o), .alloc_idx_o(alloc_idx),
      .cdb_i(cdb_i),
      .rd_idx_a_i(rob_idx_a), .rd_idx_b_i(rob_idx_b),
      .rd_a_o(rob_rd_a), .rd_b_o(rob_rd_b),
      .commit_o(commit_o)
   );

   operand_select i_opsel (
      .clk(clk), .rst_n_i(rst_n_i),
      .req_i(dispatch_req_i), .accept_i(accept), .dest_idx_i(alloc_idx),
      .rf_addr_a_o(rf_addr_a), .rf_addr_b_o(rf_addr_b),
      .rob_idx_a_o(rob_idx_a), .rob_idx_b_o(rob_idx_b),
      .rf_a_i(rf_rd_a), .rf_b_i(rf_rd_b), .rob_a_i(rob_rd_a), .rob_b_i(rob_rd_b),
      .operands_o(operands_o)
   );

endmodule

`default_nettype wire

/* rtl/operand_select.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module operand_select (
   input  logic                          clk,
   input  logic                          rst_n_i,
   input  dispatch_pkg::dispatch_req_t   req_i,
   input  logic                          accept_i,
   input  logic [`ROB_IDX_W-1:0]         dest_idx_i,    // Slot from ROB tail
   output logic [`ARCH_ADDR_W-1:0]       rf_addr_a_o,
   output logic [`ARCH_ADDR_W-1:0]       rf_addr_b_o,
   output logic [`ROB_IDX_W-1:0]         rob_idx_a_o,
   output logic [`ROB_IDX_W-1:0]         rob_idx_b_o,
   input  rob_pkg::operand_read_t        rf_a_i,
   input  rob_pkg::operand_read_t        rf_b_i,
   input  rob_pkg::operand_read_t        rob_a_i,
   input  rob_pkg::operand_read_t        rob_b_i,
   output dispatch_pkg::operand_bundle_t operands_o
);

   import dispatch_pkg::*;
   import rob_pkg::*;

   logic            src_rob_a;   // rs1 still in flight
   logic            src_rob_b;
   operand_read_t   rs1_rd;
   operand_read_t   rs2_rd;
   logic            use_imm;
   operand_bundle_t bundle_d;
   operand_bundle_t bundle_q;

   // ==========================================================
   // Address split, both sources read in parallel
   // ==========================================================
   assign src_rob_a   = req_i.rs1_phys[`PHYS_ADDR_W-1];
   assign src_rob_b   = req_i.rs2_phys[`PHYS_ADDR_W-1];
   assign rf_addr_a_o = req_i.rs1_phys[`ARCH_ADDR_W-1:0];
   assign rf_addr_b_o = req_i.rs2_phys[`ARCH_ADDR_W-1:0];
   assign rob_idx_a_o = req_i.rs1_phys[`ROB_IDX_W-1:0];
   assign rob_idx_b_o = req_i.rs2_phys[`ROB_IDX_W-1:0];

   assign rs1_rd  = src_rob_a ? rob_a_i : rf_a_i;
   assign rs2_rd  = src_rob_b ? rob_b_i : rf_b_i;
   assign use_imm = (req_i.opcode == OP_IMM) || (req_i.opcode == OP_STORE);

   // Immediate is ready by construction, store data stays rs2
   assign bundle_d = '{valid:    1'b1,
                       opcode:   req_i.opcode,
                       a_data:   rs1_rd.data,
                       a_ready:  rs1_rd.ready,
                       b_data:   use_imm ? req_i.imm : rs2_rd.data,
                       b_ready:  use_imm | rs2_rd.ready,
                       st_data:  rs2_rd.data,
                       st_ready: rs2_rd.ready,
                       dest_idx: dest_idx_i};

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         bundle_q.valid <= 1'b0;
      end else if (accept_i) begin
         bundle_q <= bundle_d;
      end else begin
         bundle_q.valid <= 1'b0;   // Bubble, payload holds
      end
   end

   assign operands_o = bundle_q;

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module reorder_buffer (
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  dispatch_pkg::dispatch_req_t alloc_i,       // valid means accepted
   output logic                        alloc_ready_o,
   output logic [`ROB_IDX_W-1:0]       alloc_idx_o,   // Slot the request lands in
   input  rob_pkg::cdb_result_t        cdb_i,
   input  logic [`ROB_IDX_W-1:0]       rd_idx_a_i,
   input  logic [`ROB_IDX_W-1:0]       rd_idx_b_i,
   output rob_pkg::operand_read_t      rd_a_o,
   output rob_pkg::operand_read_t      rd_b_o,
   output rob_pkg::commit_t            commit_o
);

   import dispatch_pkg::*;
   import rob_pkg::*;

   // ==========================================================
   // Storage, pointers, occupancy
   // ==========================================================
   rob_entry_t              entries_q [`ROB_DEPTH];
   logic [`ROB_IDX_W-1:0]   head_q;      // Oldest in flight
   logic [`ROB_IDX_W-1:0]   tail_q;      // Next slot to allocate
   logic [`ROB_IDX_W:0]     count_q;     // 0..ROB_DEPTH, one extra bit for full
   commit_t                 commit_q;
   logic                    alloc_fire;
   logic                    retire;

   assign alloc_ready_o = (count_q != `ROB_DEPTH);
   assign alloc_fire    = alloc_i.valid && alloc_ready_o;   // Guard against overrun
   assign retire        = (entries_q[head_q].state == ROB_DONE);
   assign alloc_idx_o   = tail_q;
   assign commit_o      = commit_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else begin
         if (retire) begin
            head_q <= head_q + 1'b1;   // Wraps at ROB_DEPTH
         end
         if (alloc_fire) begin
            tail_q <= tail_q + 1'b1;
         end
         case ({alloc_fire, retire})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;   // Alloc and retire cancel out
         endcase
      end
   end

   // ==========================================================
   // Entry update: writeback, retire, allocate
   // ==========================================================
   // The three never hit the same slot in one cycle
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `ROB_DEPTH; i++) begin
            entries_q[i].state <= ROB_FREE;
         end
      end else begin
         if (cdb_i.valid) begin
            entries_q[cdb_i.idx].state <= ROB_DONE;
            entries_q[cdb_i.idx].data  <= cdb_i.data;
         end
         if (retire) begin
            entries_q[head_q].state <= ROB_FREE;
         end
         if (alloc_fire) begin
            entries_q[tail_q].state     <= ROB_BUSY;
            entries_q[tail_q].rd        <= alloc_i.rd;
            entries_q[tail_q].writes_rd <= (alloc_i.opcode != OP_STORE);
         end
      end
   end

   // Registered commit, visible the cycle after retire
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         commit_q.valid <= 1'b0;
      end else begin
         commit_q.valid <= retire;
         if (retire) begin
            commit_q.we   <= entries_q[head_q].writes_rd;
            commit_q.rd   <= entries_q[head_q].rd;
            commit_q.data <= entries_q[head_q].data;
         end
      end
   end

   // ==========================================================
   // Operand reads, pre-edge state
   // ==========================================================
   // Free or done slots hold usable data, only busy ones wait
   function automatic operand_read_t read_entry(input rob_entry_t e);
      return '{data: e.data, ready: (e.state != ROB_BUSY)};
   endfunction

   assign rd_a_o = read_entry(entries_q[rd_idx_a_i]);
   assign rd_b_o = read_entry(entries_q[rd_idx_b_i]);

endmodule

`default_nettype wire

/* rtl/arch_reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dispatch_consts.svh"

module arch_reg_file (
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic [`ARCH_ADDR_W-1:0]   rd_addr_a_i,
   input  logic [`ARCH_ADDR_W-1:0]   rd_addr_b_i,
   input  rob_pkg::commit_t          commit_i,     // From ROB head
   output rob_pkg::operand_read_t    rd_a_o,
   output rob_pkg::operand_read_t    rd_b_o
);

   logic [`XLEN-1:0] regs_q [`NUM_ARCH_REGS];   // Committed state
   logic             wr_en;

   // x0 is hardwired, stores carry we low
   assign wr_en = commit_i.valid && commit_i.we && (commit_i.rd != '0);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en) begin
         regs_q[commit_i.rd] <= commit_i.data;
      end
   end

   // ==========================================================
   // Read ports, combinational, committed data always ready
   // ==========================================================
   assign rd_a_o = '{data:  (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i],
                     ready: 1'b1};
   assign rd_b_o = '{data:  (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i],
                     ready: 1'b1};

endmodule

`default_nettype wire

/* rtl/rob_pkg.sv */
`default_nettype none

`include "dispatch_consts.svh"

package rob_pkg;

   // Lifecycle of one ROB slot
   typedef enum logic [1:0] {
      ROB_FREE = 2'd0,
      ROB_BUSY = 2'd1,   // Allocated, result pending
      ROB_DONE = 2'd2    // Result in, waiting to reach head
   } rob_state_e;

   typedef struct packed {
      rob_state_e                state;
      logic [`ARCH_ADDR_W-1:0]   rd;
      logic                      writes_rd;  // Low for stores
      logic [`XLEN-1:0]          data;
   } rob_entry_t;

   // Result broadcast, one per cycle
   typedef struct packed {
      logic                      valid;
      logic [`ROB_IDX_W-1:0]     idx;
      logic [`XLEN-1:0]          data;
   } cdb_result_t;

   // In-order retirement record
   typedef struct packed {
      logic                      valid;
      logic                      we;
      logic [`ARCH_ADDR_W-1:0]   rd;
      logic [`XLEN-1:0]          data;
   } commit_t;

   typedef struct packed {
      logic [`XLEN-1:0]          data;
      logic                      ready;
   } operand_read_t;

endpackage

`default_nettype wire

/* rtl/dispatch_pkg.sv */
`default_nettype none

`include "dispatch_consts.svh"

package dispatch_pkg;

   // Instruction class, picks operand B source and rd write
   typedef enum logic [1:0] {
      OP_REG   = 2'd0,   // rs1 op rs2
      OP_IMM   = 2'd1,   // rs1 op imm, writes rd
      OP_STORE = 2'd2    // Address from rs1 + imm, data from rs2
   } opcode_e;

   // Request from issue, held unchanged while refused
   typedef struct packed {
      logic                      valid;
      opcode_e                   opcode;
      logic [`PHYS_ADDR_W-1:0]   rs1_phys;
      logic [`PHYS_ADDR_W-1:0]   rs2_phys;
      logic [`XLEN-1:0]          imm;
      logic [`ARCH_ADDR_W-1:0]   rd;
   } dispatch_req_t;

   // Registered operands towards execution
   typedef struct packed {
      logic                      valid;
      opcode_e                   opcode;
      logic [`XLEN-1:0]          a_data;
      logic                      a_ready;
      logic [`XLEN-1:0]          b_data;     // rs2 or immediate
      logic                      b_ready;
      logic [`XLEN-1:0]          st_data;    // Always the rs2 read
      logic                      st_ready;
      logic [`ROB_IDX_W-1:0]     dest_idx;   // Own ROB entry
   } operand_bundle_t;

endpackage

`default_nettype wire

/* rtl/dispatch_consts.svh */
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// ==========================================================
// Datapath and architectural registers
// ==========================================================
`define XLEN           32     // RV32I data width
`define NUM_ARCH_REGS  32
`define ARCH_ADDR_W    5      // x0..x31

// ==========================================================
// Reorder buffer
// ==========================================================
`define ROB_DEPTH      32
`define ROB_IDX_W      5
// Physical operand address, top bit selects the ROB
`define PHYS_ADDR_W    6

`endif
